/* hdl/route_pkg.sv */
// Shared widths, vector types, cell and sequencer enums, wave step code function
package route_pkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------
	// Coordinates limit the grid to 16 by 16
	localparam int COORD_W  = 4;
	localparam int WEIGHT_W = 4;
	// Worst case is 256 cells of weight 15
	localparam int COST_W   = 12;
	localparam int STEP_W   = 9;

	typedef logic [COORD_W-1:0]  coord_t;
	typedef logic [WEIGHT_W-1:0] weight_t;
	typedef logic [COST_W-1:0]   cost_t;
	typedef logic [STEP_W-1:0]   step_t;

	// ----------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------
	// Bit 1 set means the cell carries a wave code
	typedef enum logic [1:0] {
		CELL_FREE    = 2'd0,
		CELL_BLOCKED = 2'd1,
		CELL_WAVE_A  = 2'd2,
		CELL_WAVE_B  = 2'd3
	} cell_state_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SEED,
		ST_FILL,
		ST_RETRACE,
		ST_CLEAN,
		ST_REPORT
	} ctrl_state_t;

	// Wave code of distance d, runs A A B B A A
	function automatic cell_state_t step_code(input step_t d);
		return d[1] ? CELL_WAVE_B : CELL_WAVE_A;
	endfunction

endpackage

/* hdl/router_ctrl.sv */
// Routing sequencer FSM, map load row counter, net handshake and result registers
module router_ctrl import route_pkg::*; #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 16
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   load_valid_i,
	input  logic   net_valid_i,
	input  coord_t src_x_i,
	input  coord_t src_y_i,
	input  coord_t dst_x_i,
	input  coord_t dst_y_i,
	input  logic   reached_i,
	input  logic   stalled_i,
	input  logic   retrace_done_i,
	input  cost_t  cost_i,
	output logic   load_ready_o,
	output logic   net_ready_o,
	output logic   row_we_o,
	output coord_t row_idx_o,
	output logic   seed_o,
	output logic   expand_o,
	output logic   start_o,
	output logic   clear_o,
	output coord_t src_x_o,
	output coord_t src_y_o,
	output coord_t dst_x_o,
	output coord_t dst_y_o,
	output logic   busy_o,
	output logic   result_valid_o,
	output logic   route_ok_o,
	output cost_t  cost_o
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	coord_t      row_cnt;
	logic        map_loaded;
	logic        found;
	logic        net_fire;

	// ----------------------------------------------------------
	// Handshakes and strobes
	// ----------------------------------------------------------
	assign load_ready_o = (state == ST_IDLE);
	// A pending map beat wins over a new net
	assign net_ready_o  = (state == ST_IDLE) && map_loaded && !result_valid_o && !load_valid_i;
	assign net_fire     = net_valid_i && net_ready_o;
	assign row_we_o     = load_valid_i && load_ready_o;
	assign row_idx_o    = row_cnt;

	assign seed_o   = (state == ST_SEED);
	assign expand_o = (state == ST_FILL) && !reached_i && !stalled_i;
	assign start_o  = (state == ST_FILL) && reached_i;
	assign clear_o  = (state == ST_CLEAN);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:    if (net_fire) state_nxt = ST_SEED;
			ST_SEED:    state_nxt = ST_FILL;
			// Failed nets skip the retrace
			ST_FILL: begin
				if (reached_i)
					state_nxt = ST_RETRACE;
				else if (stalled_i)
					state_nxt = ST_CLEAN;
			end
			ST_RETRACE: if (retrace_done_i) state_nxt = ST_CLEAN;
			ST_CLEAN:   state_nxt = ST_REPORT;
			default:    state_nxt = ST_IDLE;
		endcase
	end

	// ----------------------------------------------------------
	// Control registers
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_IDLE;
			row_cnt        <= '0;
			map_loaded     <= 1'b0;
			found          <= 1'b0;
			busy_o         <= 1'b0;
			result_valid_o <= 1'b0;
			route_ok_o     <= 1'b0;
			cost_o         <= '0;
		end else begin
			state          <= state_nxt;
			result_valid_o <= 1'b0;
			// Last row completes the map and any other beat leaves it partial
			if (row_we_o) begin
				if (row_cnt == coord_t'(GRID_H - 1)) begin
					row_cnt    <= '0;
					map_loaded <= 1'b1;
				end else begin
					row_cnt    <= row_cnt + coord_t'(1);
					map_loaded <= 1'b0;
				end
			end
			if (net_fire)
				busy_o <= 1'b1;
			if (state == ST_SEED)
				found <= 1'b0;
			else if (start_o)
				found <= 1'b1;
			if (state == ST_REPORT) begin
				result_valid_o <= 1'b1;
				busy_o         <= 1'b0;
				route_ok_o     <= found;
				cost_o         <= found ? cost_i : '0;
			end
		end
	end

	// Accepted net endpoints
	always_ff @(posedge clk) begin
		if (net_fire) begin
			src_x_o <= src_x_i;
			src_y_o <= src_y_i;
			dst_x_o <= dst_x_i;
			dst_y_o <= dst_y_i;
		end
	end

	// Busy covers every state past idle
	a_row_we_idle: assert property (@(posedge clk) disable iff (!rst_n)
		row_we_o |-> !busy_o)
		else $error("map row written during routing");

	a_net_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		net_fire |-> (src_x_i < GRID_W) && (dst_x_i < GRID_W) &&
		             (src_y_i < GRID_H) && (dst_y_i < GRID_H))
		else $error("net endpoint outside the grid");

endmodule

/* hdl/map_wavefront.sv */
// Cell state array with row load, seeding, wave expansion, path marking and clearing
module map_wavefront import route_pkg::*; #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              row_we_i,
	input  coord_t            row_idx_i,
	input  logic [GRID_W-1:0] load_blocked_i,
	input  logic              seed_i,
	input  logic              expand_i,
	input  logic              clear_i,
	input  coord_t            src_x_i,
	input  coord_t            src_y_i,
	input  coord_t            dst_x_i,
	input  coord_t            dst_y_i,
	input  coord_t            pos_x_i,
	input  coord_t            pos_y_i,
	input  logic              mark_i,
	output logic              reached_o,
	output logic              stalled_o,
	output step_t             reach_step_o,
	output cell_state_t       nbr_down_o,
	output cell_state_t       nbr_up_o,
	output cell_state_t       nbr_right_o,
	output cell_state_t       nbr_left_o
);

	cell_state_t cells     [GRID_H][GRID_W];
	cell_state_t cells_nxt [GRID_H][GRID_W];
	step_t       step;
	cell_state_t cur_code;
	cell_state_t nxt_code;
	logic        grow;

	// Cells past the edge look blocked
	function automatic cell_state_t cell_at(input int y, input int x);
		if (y < 0 || y >= GRID_H || x < 0 || x >= GRID_W)
			return CELL_BLOCKED;
		return cells[y][x];
	endfunction

	assign cur_code     = step_code(step);
	assign nxt_code     = step_code(step + step_t'(1));
	assign reach_step_o = step;

	// Neighbors of the retrace position
	assign nbr_down_o  = cell_at(int'(pos_y_i) + 1, int'(pos_x_i));
	assign nbr_up_o    = cell_at(int'(pos_y_i) - 1, int'(pos_x_i));
	assign nbr_right_o = cell_at(int'(pos_y_i), int'(pos_x_i) + 1);
	assign nbr_left_o  = cell_at(int'(pos_y_i), int'(pos_x_i) - 1);

	// ----------------------------------------------------------
	// Next map
	// ----------------------------------------------------------
	always_comb begin
		cells_nxt = cells;
		grow      = 1'b0;
		if (row_we_i) begin
			for (int x = 0; x < GRID_W; x++)
				cells_nxt[row_idx_i][x] = load_blocked_i[x] ? CELL_BLOCKED : CELL_FREE;
		end else if (seed_i) begin
			// Source written last so it survives when it equals the sink
			cells_nxt[dst_y_i][dst_x_i] = CELL_FREE;
			cells_nxt[src_y_i][src_x_i] = CELL_WAVE_A;
		end else if (expand_i) begin
			// Free cells touching the current front join it
			for (int y = 0; y < GRID_H; y++) begin
				for (int x = 0; x < GRID_W; x++) begin
					if (cells[y][x] == CELL_FREE &&
					    (cell_at(y + 1, x) == cur_code || cell_at(y - 1, x) == cur_code ||
					     cell_at(y, x + 1) == cur_code || cell_at(y, x - 1) == cur_code)) begin
						cells_nxt[y][x] = nxt_code;
						grow            = 1'b1;
					end
				end
			end
		end else if (mark_i) begin
			cells_nxt[pos_y_i][pos_x_i] = CELL_BLOCKED;
		end else if (clear_i) begin
			for (int y = 0; y < GRID_H; y++) begin
				for (int x = 0; x < GRID_W; x++) begin
					if (cells[y][x] inside {CELL_WAVE_A, CELL_WAVE_B})
						cells_nxt[y][x] = CELL_FREE;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		cells <= cells_nxt;
	end

	// ----------------------------------------------------------
	// Step count and fill status
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step      <= '0;
			reached_o <= 1'b0;
			stalled_o <= 1'b0;
		end else if (seed_i) begin
			step      <= '0;
			reached_o <= (src_x_i == dst_x_i) && (src_y_i == dst_y_i);
			stalled_o <= 1'b0;
		end else if (expand_i) begin
			step      <= step + step_t'(1);
			reached_o <= cells_nxt[dst_y_i][dst_x_i] inside {CELL_WAVE_A, CELL_WAVE_B};
			stalled_o <= !grow;
		end
	end

	// Retrace only walks over cells the wave reached
	a_mark_on_wave: assert property (@(posedge clk) disable iff (!rst_n)
		mark_i |-> cells[pos_y_i][pos_x_i] != CELL_FREE)
		else $error("path mark on a free cell");

endmodule

/* hdl/weight_store.sv */
// Per-cell weight register array with row load and registered single-cell read
module weight_store import route_pkg::*; #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 16
) (
	input  logic                       clk,
	input  logic                       row_we_i,
	input  coord_t                     row_idx_i,
	input  logic [GRID_W*WEIGHT_W-1:0] load_weights_i,
	input  coord_t                     pos_x_i,
	input  coord_t                     pos_y_i,
	output weight_t                    weight_o
);

	weight_t weights [GRID_H][GRID_W];

	// ----------------------------------------------------------
	// Row write, column c sits at bits c*WEIGHT_W upward
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (row_we_i) begin
			for (int x = 0; x < GRID_W; x++)
				weights[row_idx_i][x] <= load_weights_i[x*WEIGHT_W +: WEIGHT_W];
		end
	end

	// ----------------------------------------------------------
	// Lookup, one cycle behind the position
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		weight_o <= weights[pos_y_i][pos_x_i];
	end

endmodule

/* hdl/path_retracer.sv */
// Retrace FSM walking from sink to source by wave codes, path marking and cost sum
module path_retracer import route_pkg::*; #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 16
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start_i,
	input  step_t       reach_step_i,
	input  coord_t      src_x_i,
	input  coord_t      src_y_i,
	input  coord_t      dst_x_i,
	input  coord_t      dst_y_i,
	input  cell_state_t nbr_down_i,
	input  cell_state_t nbr_up_i,
	input  cell_state_t nbr_right_i,
	input  cell_state_t nbr_left_i,
	input  weight_t     weight_i,
	output coord_t      pos_x_o,
	output coord_t      pos_y_o,
	output logic        mark_o,
	output logic        done_o,
	output cost_t       cost_o
);

	typedef enum logic [1:0] {
		RT_IDLE,
		RT_LOOK,
		RT_MOVE,
		RT_DONE
	} rt_state_t;

	rt_state_t   state;
	step_t       step;
	cell_state_t want;
	logic        at_src;
	logic        at_dst;

	// Predecessor code, unique among the neighbors since the grid is bipartite
	assign want   = step_code(step - step_t'(1));
	assign at_src = (pos_x_o == src_x_i) && (pos_y_o == src_y_i);
	assign at_dst = (pos_x_o == dst_x_i) && (pos_y_o == dst_y_i);

	// Every visited cell gets blocked in its lookup cycle
	assign mark_o = (state == RT_LOOK);
	assign done_o = (state == RT_DONE);

	// ----------------------------------------------------------
	// Walk
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= RT_IDLE;
			step    <= '0;
			pos_x_o <= '0;
			pos_y_o <= '0;
			cost_o  <= '0;
		end else begin
			case (state)
				RT_IDLE: begin
					if (start_i) begin
						pos_x_o <= dst_x_i;
						pos_y_o <= dst_y_i;
						step    <= reach_step_i;
						cost_o  <= '0;
						state   <= RT_LOOK;
					end
				end
				RT_LOOK: state <= at_src ? RT_DONE : RT_MOVE;
				RT_MOVE: begin
					// Weight of this cell arrives now, sink excluded
					if (!at_dst)
						cost_o <= cost_o + cost_t'(weight_i);
					step  <= step - step_t'(1);
					state <= RT_LOOK;
					// Priority down, up, right, left
					if (nbr_down_i == want)
						pos_y_o <= pos_y_o + coord_t'(1);
					else if (nbr_up_i == want)
						pos_y_o <= pos_y_o - coord_t'(1);
					else if (nbr_right_i == want)
						pos_x_o <= pos_x_o + coord_t'(1);
					else
						pos_x_o <= pos_x_o - coord_t'(1);
				end
				default: state <= RT_IDLE;
			endcase
		end
	end

	a_pos_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		state != RT_IDLE |-> (pos_x_o < GRID_W) && (pos_y_o < GRID_H))
		else $error("retrace left the grid");

endmodule

/* hdl/maze_router_top.sv */
// Maze router top level with sequencer, map and wavefront, weight store and retracer
module maze_router_top import route_pkg::*; #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 16
) (
	input  logic                       clk,
	input  logic                       rst_n,
	// Map load stream, one row per beat
	input  logic                       load_valid_i,
	output logic                       load_ready_o,
	input  logic [GRID_W-1:0]          load_blocked_i,
	input  logic [GRID_W*WEIGHT_W-1:0] load_weights_i,
	// Net request
	input  logic                       net_valid_i,
	output logic                       net_ready_o,
	input  coord_t                     src_x_i,
	input  coord_t                     src_y_i,
	input  coord_t                     dst_x_i,
	input  coord_t                     dst_y_i,
	// Result
	output logic                       busy_o,
	output logic                       result_valid_o,
	output logic                       route_ok_o,
	output cost_t                      cost_o
);

	logic        row_we;
	coord_t      row_idx;
	logic        seed;
	logic        expand;
	logic        start;
	logic        clear;
	coord_t      net_src_x;
	coord_t      net_src_y;
	coord_t      net_dst_x;
	coord_t      net_dst_y;
	logic        reached;
	logic        stalled;
	step_t       reach_step;
	cell_state_t nbr_down;
	cell_state_t nbr_up;
	cell_state_t nbr_right;
	cell_state_t nbr_left;
	coord_t      pos_x;
	coord_t      pos_y;
	logic        mark;
	weight_t     weight;
	logic        retrace_done;
	cost_t       retrace_cost;

	router_ctrl #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_ctrl (
		.clk, .rst_n, .load_valid_i, .net_valid_i,
		.src_x_i, .src_y_i, .dst_x_i, .dst_y_i,
		.reached_i(reached), .stalled_i(stalled),
		.retrace_done_i(retrace_done), .cost_i(retrace_cost),
		.load_ready_o, .net_ready_o, .row_we_o(row_we), .row_idx_o(row_idx),
		.seed_o(seed), .expand_o(expand), .start_o(start), .clear_o(clear),
		.src_x_o(net_src_x), .src_y_o(net_src_y), .dst_x_o(net_dst_x), .dst_y_o(net_dst_y),
		.busy_o, .result_valid_o, .route_ok_o, .cost_o
	);

	map_wavefront #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_map (
		.clk, .rst_n, .row_we_i(row_we), .row_idx_i(row_idx), .load_blocked_i,
		.seed_i(seed), .expand_i(expand), .clear_i(clear),
		.src_x_i(net_src_x), .src_y_i(net_src_y), .dst_x_i(net_dst_x), .dst_y_i(net_dst_y),
		.pos_x_i(pos_x), .pos_y_i(pos_y), .mark_i(mark),
		.reached_o(reached), .stalled_o(stalled), .reach_step_o(reach_step),
		.nbr_down_o(nbr_down), .nbr_up_o(nbr_up), .nbr_right_o(nbr_right), .nbr_left_o(nbr_left)
	);

	weight_store #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_weights (
		.clk, .row_we_i(row_we), .row_idx_i(row_idx), .load_weights_i,
		.pos_x_i(pos_x), .pos_y_i(pos_y), .weight_o(weight)
	);

	path_retracer #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_retracer (
		.clk, .rst_n, .start_i(start), .reach_step_i(reach_step),
		.src_x_i(net_src_x), .src_y_i(net_src_y), .dst_x_i(net_dst_x), .dst_y_i(net_dst_y),
		.nbr_down_i(nbr_down), .nbr_up_i(nbr_up), .nbr_right_i(nbr_right), .nbr_left_i(nbr_left),
		.weight_i(weight), .pos_x_o(pos_x), .pos_y_o(pos_y), .mark_o(mark),
		.done_o(retrace_done), .cost_o(retrace_cost)
	);

endmodule

/* sim/tb_route_model.svh */
// Reference router model with BFS distances, priority retrace, path cost and path blocking
`ifndef TB_ROUTE_MODEL_SVH
`define TB_ROUTE_MODEL_SVH

// Map as later nets see it, earlier paths included
bit ref_blocked [GRID_H][GRID_W];
int ref_weight  [GRID_H][GRID_W];
int ref_dist    [GRID_H][GRID_W];

// Neighbor order down, up, right, left
int nbr_dx [4] = '{0, 0, 1, -1};
int nbr_dy [4] = '{1, -1, 0, 0};

function automatic bit in_grid(input int x, input int y);
	return x >= 0 && x < GRID_W && y >= 0 && y < GRID_H;
endfunction

// Breadth-first distances from the source, -1 where the wave never gets
function automatic void flood_distances(input int sx, input int sy);
	int qx[$];
	int qy[$];
	int cx;
	int cy;
	int nx;
	int ny;
	for (int y = 0; y < GRID_H; y++) begin
		for (int x = 0; x < GRID_W; x++)
			ref_dist[y][x] = -1;
	end
	ref_dist[sy][sx] = 0;
	qx.push_back(sx);
	qy.push_back(sy);
	while (qx.size() > 0) begin
		cx = qx.pop_front();
		cy = qy.pop_front();
		for (int k = 0; k < 4; k++) begin
			nx = cx + nbr_dx[k];
			ny = cy + nbr_dy[k];
			if (in_grid(nx, ny) && !ref_blocked[ny][nx] && ref_dist[ny][nx] < 0) begin
				ref_dist[ny][nx] = ref_dist[cy][cx] + 1;
				qx.push_back(nx);
				qy.push_back(ny);
			end
		end
	end
endfunction

// Walk back from the sink, block the path, sum inner weights
function automatic bit trace_route(input int sx, input int sy, input int dx, input int dy,
                                   output int cost);
	int  cx;
	int  cy;
	int  nx;
	int  ny;
	int  d;
	bit  moved;
	cost = 0;
	flood_distances(sx, sy);
	if (ref_dist[dy][dx] < 0)
		return 1'b0;
	cx = dx;
	cy = dy;
	d  = ref_dist[dy][dx];
	ref_blocked[cy][cx] = 1'b1;
	while (d > 0) begin
		moved = 1'b0;
		for (int k = 0; k < 4 && !moved; k++) begin
			nx = cx + nbr_dx[k];
			ny = cy + nbr_dy[k];
			if (in_grid(nx, ny) && ref_dist[ny][nx] == d - 1) begin
				cx    = nx;
				cy    = ny;
				moved = 1'b1;
			end
		end
		d--;
		ref_blocked[cy][cx] = 1'b1;
		// Source excluded
		if (d > 0)
			cost += ref_weight[cy][cx];
	end
	return 1'b1;
endfunction

`endif

/* sim/tb_maze_router.sv */
// Maze router testbench with clock, reset, random maps and nets, checks and watchdog
module tb_maze_router import route_pkg::*; ();

	localparam int GRID_W        = 16;
	localparam int GRID_H        = 16;
	localparam int HALF_PERIOD   = 20;
	localparam int DRIVE_DELAY   = 5;
	localparam int SEED          = 2;
	localparam int N_MAPS        = 6;
	localparam int NETS_PER_MAP  = 5;
	localparam int NET_CYCLES    = 8 * GRID_W * GRID_H;
	localparam int WATCHDOG_TIME = N_MAPS * NETS_PER_MAP * NET_CYCLES * 2 * HALF_PERIOD;

	logic                       clk;
	logic                       rst_n;
	logic                       load_valid_i;
	logic                       load_ready_o;
	logic [GRID_W-1:0]          load_blocked_i;
	logic [GRID_W*WEIGHT_W-1:0] load_weights_i;
	logic                       net_valid_i;
	logic                       net_ready_o;
	coord_t                     src_x_i;
	coord_t                     src_y_i;
	coord_t                     dst_x_i;
	coord_t                     dst_y_i;
	logic                       busy_o;
	logic                       result_valid_o;
	logic                       route_ok_o;
	cost_t                      cost_o;

	`include "tb_route_model.svh"

	maze_router_top #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_dut (
		.clk, .rst_n, .load_valid_i, .load_ready_o, .load_blocked_i, .load_weights_i,
		.net_valid_i, .net_ready_o, .src_x_i, .src_y_i, .dst_x_i, .dst_y_i,
		.busy_o, .result_valid_o, .route_ok_o, .cost_o
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// ----------------------------------------------------------
	// Checking
	// ----------------------------------------------------------
	task automatic check_value(input string name, input int unsigned got,
	                           input int unsigned exp);
		if (got != exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	initial begin
		#WATCHDOG_TIME;
		abort_run("Simulation timed out before all nets were routed");
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	// About a quarter blocked and optionally a full wall column
	task automatic make_map(input bit with_wall, output int wall_x);
		wall_x = -1;
		for (int y = 0; y < GRID_H; y++) begin
			for (int x = 0; x < GRID_W; x++) begin
				ref_blocked[y][x] = ($urandom % 4) == 0;
				ref_weight[y][x]  = $urandom % 16;
			end
		end
		if (with_wall) begin
			wall_x = 2 + $urandom % (GRID_W - 4);
			for (int y = 0; y < GRID_H; y++)
				ref_blocked[y][wall_x] = 1'b1;
		end
	endtask

	task automatic pick_free_cell(input int x_lo, input int x_hi, input int ex, input int ey,
	                              output int px, output int py);
		int cand_x[$];
		int cand_y[$];
		int idx;
		for (int y = 0; y < GRID_H; y++) begin
			for (int x = x_lo; x <= x_hi; x++) begin
				if (!ref_blocked[y][x] && !(x == ex && y == ey)) begin
					cand_x.push_back(x);
					cand_y.push_back(y);
				end
			end
		end
		if (cand_x.size() == 0) begin
			abort_run("No free cell left for a net endpoint");
		end else begin
			idx = $urandom % cand_x.size();
			px  = cand_x[idx];
			py  = cand_y[idx];
		end
	endtask

	task automatic load_map();
		int waits;
		for (int y = 0; y < GRID_H; y++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			load_valid_i = 1'b1;
			for (int x = 0; x < GRID_W; x++) begin
				load_blocked_i[x] = ref_blocked[y][x];
				load_weights_i[x*WEIGHT_W +: WEIGHT_W] = weight_t'(ref_weight[y][x]);
			end
			@(negedge clk);
			waits = 0;
			while (!load_ready_o) begin
				waits++;
				if (waits > NET_CYCLES)
					abort_run("A map row was never accepted");
				@(negedge clk);
			end
			@(posedge clk);
			#DRIVE_DELAY;
			load_valid_i = 1'b0;
			// Nets wait until the last row is in
			@(negedge clk);
			check_value("net_ready_o", net_ready_o, y == GRID_H - 1);
		end
	endtask

	// Request stays asserted through routing and the result pulse
	task automatic route_net(input int sx, input int sy, input int dx, input int dy);
		int exp_cost;
		bit exp_ok;
		int waits;
		exp_ok = trace_route(sx, sy, dx, dy, exp_cost);
		@(posedge clk);
		#DRIVE_DELAY;
		net_valid_i = 1'b1;
		src_x_i     = coord_t'(sx);
		src_y_i     = coord_t'(sy);
		dst_x_i     = coord_t'(dx);
		dst_y_i     = coord_t'(dy);
		@(negedge clk);
		waits = 0;
		while (!net_ready_o) begin
			waits++;
			if (waits > NET_CYCLES)
				abort_run("A net request was never accepted");
			@(negedge clk);
		end
		@(negedge clk);
		check_value("busy_o", busy_o, 1);
		waits = 0;
		while (!result_valid_o) begin
			check_value("busy_o", busy_o, 1);
			check_value("net_ready_o", net_ready_o, 0);
			check_value("load_ready_o", load_ready_o, 0);
			waits++;
			if (waits > NET_CYCLES)
				abort_run("No result for a net within the cycle limit");
			@(negedge clk);
		end
		check_value("route_ok_o", route_ok_o, exp_ok);
		check_value("cost_o", cost_o, exp_cost);
		check_value("busy_o", busy_o, 0);
		check_value("net_ready_o", net_ready_o, 0);
		@(posedge clk);
		#DRIVE_DELAY;
		net_valid_i = 1'b0;
		// Single pulse and the held request is not taken again
		@(negedge clk);
		check_value("result_valid_o", result_valid_o, 0);
		check_value("busy_o", busy_o, 0);
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		int wall_x;
		bit with_wall;
		bit retry;
		int sx;
		int sy;
		int dx;
		int dy;
		int rsx;
		int rsy;
		int rdx;
		int rdy;
		void'($urandom(SEED));
		rst_n          = 1'b0;
		load_valid_i   = 1'b0;
		load_blocked_i = '0;
		load_weights_i = '0;
		net_valid_i    = 1'b0;
		src_x_i        = '0;
		src_y_i        = '0;
		dst_x_i        = '0;
		dst_y_i        = '0;
		retry          = 1'b0;
		rsx = 0;
		rsy = 0;
		rdx = 0;
		rdy = 0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("busy_o", busy_o, 0);
		check_value("result_valid_o", result_valid_o, 0);
		check_value("net_ready_o", net_ready_o, 0);
		check_value("route_ok_o", route_ok_o, 0);
		check_value("cost_o", cost_o, 0);

		for (int m = 0; m < N_MAPS; m++) begin
			with_wall = (m % 3) == 2;
			make_map(with_wall, wall_x);
			// Walled-off net from the previous map gets another try
			if (retry) begin
				ref_blocked[rsy][rsx] = 1'b0;
				ref_blocked[rdy][rdx] = 1'b0;
			end
			load_map();
			for (int n = 0; n < NETS_PER_MAP; n++) begin
				if (n == 0 && retry) begin
					sx = rsx;
					sy = rsy;
					dx = rdx;
					dy = rdy;
				end else if (n == 0 && with_wall) begin
					pick_free_cell(0, wall_x - 1, -1, -1, sx, sy);
					pick_free_cell(wall_x + 1, GRID_W - 1, -1, -1, dx, dy);
				end else begin
					pick_free_cell(0, GRID_W - 1, -1, -1, sx, sy);
					pick_free_cell(0, GRID_W - 1, sx, sy, dx, dy);
				end
				route_net(sx, sy, dx, dy);
				if (n == 0) begin
					rsx = sx;
					rsy = sy;
					rdx = dx;
					rdy = dy;
				end
			end
			retry = with_wall;
		end

		$display("TEST OK");
		$finish;
	end

endmodule

/* project.f */
+incdir+sim
hdl/route_pkg.sv
hdl/router_ctrl.sv
hdl/map_wavefront.sv
hdl/weight_store.sv
hdl/path_retracer.sv
hdl/maze_router_top.sv
sim/tb_maze_router.sv
